//--- files.f
hdl/exec_pkg.sv
hdl/insn_decode.sv
hdl/exec_sequencer.sv
hdl/operand_select.sv
hdl/barrel_shifter.sv
hdl/alu.sv
hdl/reg_bank.sv
hdl/exec_top.sv
sim/exec_tb.sv

//--- Bender.yml
package:
  name: exec_path

sources:
  - hdl/exec_pkg.sv
  - hdl/insn_decode.sv
  - hdl/exec_sequencer.sv
  - hdl/operand_select.sv
  - hdl/barrel_shifter.sv
  - hdl/alu.sv
  - hdl/reg_bank.sv
  - hdl/exec_top.sv
  - target: simulation
    files:
      - sim/exec_tb.sv

//--- sim/exec_tb.sv
module exec_tb;

	typedef struct packed {
		exec_pkg::word      value;
		exec_pkg::psr_flags flags;
		exec_pkg::reg_idx   rd;
		logic               writes;
		logic               set_flags;
		logic [1:0]         latency;
	} prediction;

	localparam int load_insns = 16;
	localparam int latency_insns = 8;
	localparam int imm_shift_insns = 16;
	localparam int reg_shift_insns = 48;
	localparam int opcode_insns = 32;
	localparam int chain_insns = 8;
	localparam int sweep_insns = 16;
	localparam int num_insns = load_insns + latency_insns + imm_shift_insns + reg_shift_insns
		+ opcode_insns + chain_insns + sweep_insns;
	localparam int cycle_limit = 20 * num_insns + 200;

	logic               clk;
	logic               rst_n;
	exec_pkg::word      insn;
	logic               insn_valid;
	logic               busy;
	logic               wb_valid;
	exec_pkg::reg_idx   wb_rd;
	exec_pkg::word      wb_value;
	exec_pkg::psr_flags flags;

	exec_pkg::word      m_regs [16];
	exec_pkg::psr_flags m_flags;
	prediction          pend;
	prediction          next_pred;
	logic [1:0]         cnt;
	logic               exp_busy;
	logic               exp_wb_valid;
	int                 errors = 0;
	int                 cycles = 0;
	int                 accepted = 0;

	exec_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.insn       (insn),
		.insn_valid (insn_valid),
		.busy       (busy),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_value   (wb_value),
		.flags      (flags)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// returns the shifter carry in bit 32 above the shifted value
	function automatic logic [32:0] shift_value(input exec_pkg::shift_kind kind,
			input exec_pkg::word v, input exec_pkg::shift_amt amt, input logic cin);
		exec_pkg::word r;
		logic          c;
		int            n;
		n = int'(amt);
		r = v;
		c = cin;
		if (n != 0) begin
			case (kind)
				exec_pkg::SHIFT_LSL: begin
					r = (n < 32) ? v << n : '0;
					c = (n < 32) ? v[32 - n] : (n == 32) && v[0];
				end
				exec_pkg::SHIFT_LSR: begin
					r = (n < 32) ? v >> n : '0;
					c = (n < 32) ? v[n - 1] : (n == 32) && v[31];
				end
				exec_pkg::SHIFT_ASR: begin
					if (n < 32)
						r = $signed(v) >>> n;
					else
						r = {32{v[31]}};
					c = (n < 32) ? v[n - 1] : v[31];
				end
				default: begin
					r = (v >> (n % 32)) | (v << (32 - n % 32));
					c = r[31];
				end
			endcase
		end
		return {c, r};
	endfunction

	function automatic exec_pkg::word alu_result(input exec_pkg::alu_op op, input exec_pkg::word a,
			input exec_pkg::word b, input logic cin, input logic vin,
			output exec_pkg::psr_flags f);
		longint        ua;
		longint        ub;
		longint        sa;
		longint        sb;
		longint        ci;
		longint        ur;
		longint        sr;
		logic          arith;
		logic          adding;
		exec_pkg::word q;
		ua = a;
		ub = b;
		sa = $signed(a);
		sb = $signed(b);
		ci = cin;
		ur = 0;
		sr = 0;
		arith = 1'b1;
		adding = 1'b0;
		case (op)
			exec_pkg::ALU_ADD, exec_pkg::ALU_CMN: begin
				ur = ua + ub;
				sr = sa + sb;
				adding = 1'b1;
			end
			exec_pkg::ALU_ADC: begin
				ur = ua + ub + ci;
				sr = sa + sb + ci;
				adding = 1'b1;
			end
			exec_pkg::ALU_SUB, exec_pkg::ALU_CMP: begin
				ur = ua - ub;
				sr = sa - sb;
			end
			exec_pkg::ALU_SBC: begin
				ur = ua - ub - (1 - ci);
				sr = sa - sb - (1 - ci);
			end
			exec_pkg::ALU_RSB: begin
				ur = ub - ua;
				sr = sb - sa;
			end
			exec_pkg::ALU_RSC: begin
				ur = ub - ua - (1 - ci);
				sr = sb - sa - (1 - ci);
			end
			default: arith = 1'b0;
		endcase
		case (op)
			exec_pkg::ALU_AND, exec_pkg::ALU_TST: q = a & b;
			exec_pkg::ALU_EOR, exec_pkg::ALU_TEQ: q = a ^ b;
			exec_pkg::ALU_ORR: q = a | b;
			exec_pkg::ALU_MOV: q = b;
			exec_pkg::ALU_BIC: q = a & ~b;
			exec_pkg::ALU_MVN: q = ~b;
			default: q = ur[31:0];
		endcase
		f.n = q[31];
		f.z = q == '0;
		if (arith) begin
			f.c = adding ? ur > 64'sd4294967295 : ur >= 0;
			f.v = (sr > 64'sd2147483647) || (sr < -64'sd2147483648);
		end else begin
			f.c = cin;
			f.v = vin;
		end
		return q;
	endfunction

	function automatic prediction predict(input exec_pkg::word w);
		prediction           p;
		exec_pkg::alu_op     op;
		exec_pkg::shift_kind kind;
		exec_pkg::shift_amt  amt;
		exec_pkg::word       base;
		exec_pkg::psr_flags  f;
		logic [32:0]         shifted;
		op = exec_pkg::alu_op'(w[24:21]);
		kind = exec_pkg::shift_kind'(w[6:5]);
		base = m_regs[w[3:0]];
		if (w[25]) begin
			base = {24'd0, w[7:0]};
			kind = exec_pkg::SHIFT_ROR;
			amt = {3'd0, w[11:8], 1'b0};
			p.latency = (amt == 8'd0) ? 2'd1 : 2'd2;
		end else if (w[4]) begin
			amt = m_regs[w[11:8]][7:0];
			p.latency = 2'd3;
		end else begin
			amt = {3'd0, w[11:7]};
			p.latency = (amt == 8'd0) ? 2'd1 : 2'd2;
		end
		// the ALU carry input is the shifter carry, the old C flag when nothing shifts
		shifted = shift_value(kind, base, amt, m_flags.c);
		p.value = alu_result(op, m_regs[w[19:16]], shifted[31:0], shifted[32], m_flags.v, f);
		p.flags = f;
		p.rd = w[15:12];
		p.set_flags = w[20];
		p.writes = !(op inside {exec_pkg::ALU_TST, exec_pkg::ALU_TEQ, exec_pkg::ALU_CMP,
			exec_pkg::ALU_CMN});
		return p;
	endfunction

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 16; i++)
				m_regs[i] <= '0;
			m_flags <= '0;
			cnt <= 2'd0;
			pend <= '0;
		end else if (cnt == 2'd0) begin
			if (insn_valid) begin
				next_pred = predict(insn);
				pend <= next_pred;
				cnt <= next_pred.latency;
				accepted++;
			end
		end else begin
			cnt <= cnt - 2'd1;
			if (cnt == 2'd1 && pend.writes)
				m_regs[pend.rd] <= pend.value;
			if (cnt == 2'd1 && pend.set_flags)
				m_flags <= pend.flags;
		end
	end

	assign exp_busy = cnt != 2'd0;
	assign exp_wb_valid = (cnt == 2'd1) && pend.writes;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic report_mismatch(input string name, input exec_pkg::word dut,
			input exec_pkg::word model);
		errors++;
		$display("mismatch %s: dut %h, model %h", name, dut, model);
	endtask

	busy_check: assert property (@(posedge clk) disable iff (!rst_n) busy == exp_busy)
		else report_mismatch("busy", {31'd0, $sampled(busy)}, {31'd0, $sampled(exp_busy)});

	wb_valid_check: assert property (@(posedge clk) disable iff (!rst_n)
		wb_valid == exp_wb_valid)
		else report_mismatch("wb_valid", {31'd0, $sampled(wb_valid)},
			{31'd0, $sampled(exp_wb_valid)});

	wb_rd_check: assert property (@(posedge clk) disable iff (!rst_n)
		exp_wb_valid |-> wb_rd == pend.rd)
		else report_mismatch("wb_rd", {28'd0, $sampled(wb_rd)}, {28'd0, $sampled(pend.rd)});

	wb_value_check: assert property (@(posedge clk) disable iff (!rst_n)
		exp_wb_valid |-> wb_value == pend.value)
		else report_mismatch("wb_value", $sampled(wb_value), $sampled(pend.value));

	flags_check: assert property (@(posedge clk) disable iff (!rst_n) flags == m_flags)
		else report_mismatch("flags", {28'd0, $sampled(flags)}, {28'd0, $sampled(m_flags)});

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit) begin
			$display("timeout after %0d cycles, the run did not finish", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic exec_pkg::word immediate_word(input exec_pkg::alu_op op, input logic s,
			input exec_pkg::reg_idx rn, input exec_pkg::reg_idx rd, input logic [3:0] rot,
			input logic [7:0] imm);
		return {4'he, 3'b001, op, s, rn, rd, rot, imm};
	endfunction

	function automatic exec_pkg::word const_shift_word(input exec_pkg::alu_op op, input logic s,
			input exec_pkg::reg_idx rn, input exec_pkg::reg_idx rd, input logic [4:0] amt,
			input exec_pkg::shift_kind kind, input exec_pkg::reg_idx rm);
		return {4'he, 3'b000, op, s, rn, rd, amt, kind, 1'b0, rm};
	endfunction

	function automatic exec_pkg::word reg_shift_word(input exec_pkg::alu_op op, input logic s,
			input exec_pkg::reg_idx rn, input exec_pkg::reg_idx rd, input exec_pkg::reg_idx rs,
			input exec_pkg::shift_kind kind, input exec_pkg::reg_idx rm);
		return {4'he, 3'b000, op, s, rn, rd, rs, 1'b0, kind, 1'b1, rm};
	endfunction

	// form 0 plain register, 1 immediate, 2 constant shift, 3 register shift
	function automatic exec_pkg::word random_insn(input exec_pkg::alu_op op, input logic s,
			input int form);
		exec_pkg::word       r;
		exec_pkg::shift_kind k;
		r = $urandom;
		k = exec_pkg::shift_kind'(r[6:5]);
		case (form)
			0: return const_shift_word(op, s, r[19:16], r[15:12], 5'd0, k, r[3:0]);
			1: return immediate_word(op, s, r[19:16], r[15:12], r[11:8], r[7:0]);
			2: return const_shift_word(op, s, r[19:16], r[15:12], r[11:7] | 5'd1, k, r[3:0]);
			default: return reg_shift_word(op, s, r[19:16], r[15:12], r[11:8], k, r[3:0]);
		endcase
	endfunction

	// called on a falling edge, returns on the falling edge after acceptance
	task automatic send(input exec_pkg::word w);
		while (busy)
			@(negedge clk);
		insn = w;
		insn_valid = 1'b1;
		@(negedge clk);
		insn_valid = 1'b0;
	endtask

	task automatic send_with_poke(input exec_pkg::word w, input exec_pkg::word junk);
		send(w);
		insn = junk;
		insn_valid = 1'b1;
		@(negedge clk);
		insn_valid = 1'b0;
	endtask

	initial begin
		exec_pkg::word      rnd;
		exec_pkg::word      junk;
		exec_pkg::shift_amt reg_amounts [6];
		exec_pkg::reg_idx   prev;
		exec_pkg::reg_idx   rd;

		insn = '0;
		insn_valid = 1'b0;
		rst_n = 1'b0;
		reg_amounts = '{8'd0, 8'd1, 8'd31, 8'd32, 8'd33, 8'd200};
		repeat (8) @(negedge clk);
		rst_n = 1'b1;
		void'($urandom(32'h60f7_c72d));

		for (int i = 0; i < load_insns; i++) begin
			rnd = $urandom;
			send(immediate_word(exec_pkg::ALU_MOV, 1'b0, 4'd0, i[3:0], rnd[11:8], rnd[7:0]));
		end

		// every operand class, each followed by an offer that must be dropped
		junk = immediate_word(exec_pkg::ALU_MOV, 1'b1, 4'd0, 4'd0, 4'd0, 8'hff);
		for (int j = 0; j < latency_insns; j++) begin
			rnd = $urandom;
			send_with_poke(random_insn(exec_pkg::alu_op'(rnd[3:0]), rnd[4], j % 4), junk);
		end

		for (int k = 0; k < 4; k++) begin
			for (int j = 0; j < imm_shift_insns / 4; j++) begin
				rnd = $urandom;
				send(const_shift_word(exec_pkg::ALU_MOV, 1'b1, 4'd0, rnd[15:12],
					(rnd[11:7] == 5'd0) ? 5'd31 : rnd[11:7], exec_pkg::shift_kind'(k[1:0]),
					rnd[3:0]));
			end
		end

		// r14 holds the amount, the operand comes from r0 to r7
		for (int k = 0; k < 4; k++) begin
			for (int j = 0; j < 6; j++) begin
				rnd = $urandom;
				send(immediate_word(exec_pkg::ALU_MOV, 1'b0, 4'd0, 4'd14, 4'd0, reg_amounts[j]));
				send(reg_shift_word(j[0] ? exec_pkg::ALU_ADC : exec_pkg::ALU_MOV, 1'b1,
					rnd[19:16], {1'b0, rnd[14:12]}, 4'd14, exec_pkg::shift_kind'(k[1:0]),
					{1'b0, rnd[2:0]}));
			end
		end

		for (int op = 0; op < 16; op++) begin
			for (int s = 0; s < 2; s++) begin
				rnd = $urandom;
				send(random_insn(exec_pkg::alu_op'(op[3:0]), s[0], int'(rnd[1:0])));
			end
		end

		prev = 4'd3;
		for (int j = 0; j < chain_insns; j++) begin
			rnd = $urandom;
			rd = rnd[15:12];
			send(const_shift_word(j[0] ? exec_pkg::ALU_SBC : exec_pkg::ALU_ADD, 1'b1, prev, rd,
				rnd[11:7], exec_pkg::shift_kind'(rnd[6:5]), prev));
			prev = rd;
		end

		// a move of each register onto itself shows the final register contents
		for (int i = 0; i < sweep_insns; i++)
			send(const_shift_word(exec_pkg::ALU_MOV, 1'b0, 4'd0, i[3:0], 5'd0,
				exec_pkg::SHIFT_LSL, i[3:0]));

		while (busy)
			@(negedge clk);
		repeat (2) @(negedge clk);

		$display("instructions %0d, cycles %0d, errors %0d", accepted, cycles, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

//--- hdl/exec_top.sv
module exec_top #(
	parameter int NUM_REGS = exec_pkg::num_regs
) (
	input  logic               clk,
	input  logic               rst_n,
	input  exec_pkg::word      insn,
	input  logic               insn_valid,
	output logic               busy,
	output logic               wb_valid,
	output exec_pkg::reg_idx   wb_rd,
	output exec_pkg::word      wb_value,
	output exec_pkg::psr_flags flags
);

	exec_pkg::data_decode data;
	exec_pkg::snd_decode  snd;
	exec_pkg::ctrl_cycle  cycle;
	exec_pkg::ctrl_cycle  next_cycle;
	exec_pkg::reg_idx     addr_a;
	exec_pkg::reg_idx     addr_b;
	exec_pkg::word        rd_value_a;
	exec_pkg::word        rd_value_b;
	exec_pkg::alu_op      alu_sel;
	exec_pkg::word        alu_a;
	exec_pkg::word        alu_b;
	exec_pkg::word        shift_in;
	exec_pkg::shift_kind  shift_kind_sel;
	exec_pkg::shift_amt   shifter_shift;
	exec_pkg::word        q_shifter;
	exec_pkg::word        q_alu;
	exec_pkg::psr_flags   q_alu_flags;
	exec_pkg::reg_idx     rd;
	logic                 c_in;
	logic                 c_shifter;
	logic                 writes_rd;
	logic                 set_flags;
	logic                 issue;

	// an instruction offered while busy is simply dropped
	assign issue = insn_valid && !busy;

	insn_decode u_decode (
		.insn (insn),
		.data (data),
		.snd  (snd)
	);

	exec_sequencer u_sequencer (
		.clk        (clk),
		.rst_n      (rst_n),
		.issue      (issue),
		.data       (data),
		.snd        (snd),
		.cycle      (cycle),
		.next_cycle (next_cycle),
		.addr_a     (addr_a),
		.addr_b     (addr_b),
		.busy       (busy)
	);

	operand_select u_operands (
		.clk            (clk),
		.rst_n          (rst_n),
		.issue          (issue),
		.data           (data),
		.snd            (snd),
		.cycle          (cycle),
		.next_cycle     (next_cycle),
		.rd_value_a     (rd_value_a),
		.rd_value_b     (rd_value_b),
		.q_shifter      (q_shifter),
		.c_shifter      (c_shifter),
		.flags          (flags),
		.alu            (alu_sel),
		.alu_a          (alu_a),
		.alu_b          (alu_b),
		.c_in           (c_in),
		.shift_in       (shift_in),
		.shift_kind_out (shift_kind_sel),
		.shifter_shift  (shifter_shift),
		.rd             (rd),
		.writes_rd      (writes_rd),
		.set_flags      (set_flags)
	);

	barrel_shifter u_shifter (
		.operand (shift_in),
		.kind    (shift_kind_sel),
		.amount  (shifter_shift),
		.c_in    (c_in),
		.result  (q_shifter),
		.c_out   (c_shifter)
	);

	alu u_alu (
		.op      (alu_sel),
		.a       (alu_a),
		.b       (alu_b),
		.c_in    (c_in),
		.v_in    (flags.v),
		.q       (q_alu),
		.q_flags (q_alu_flags)
	);

	reg_bank #(
		.NUM_REGS (NUM_REGS)
	) u_regs (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr_a     (addr_a),
		.addr_b     (addr_b),
		.rd_value_a (rd_value_a),
		.rd_value_b (rd_value_b),
		.cycle      (cycle),
		.rd         (rd),
		.writes_rd  (writes_rd),
		.set_flags  (set_flags),
		.q          (q_alu),
		.q_flags    (q_alu_flags),
		.flags      (flags),
		.wb_valid   (wb_valid),
		.wb_rd      (wb_rd),
		.wb_value   (wb_value)
	);

endmodule

//--- hdl/reg_bank.sv
module reg_bank #(
	parameter int NUM_REGS = exec_pkg::num_regs
) (
	input  logic                clk,
	input  logic                rst_n,
	input  exec_pkg::reg_idx    addr_a,
	input  exec_pkg::reg_idx    addr_b,
	output exec_pkg::word       rd_value_a,
	output exec_pkg::word       rd_value_b,
	input  exec_pkg::ctrl_cycle cycle,
	input  exec_pkg::reg_idx    rd,
	input  logic                writes_rd,
	input  logic                set_flags,
	input  exec_pkg::word       q,
	input  exec_pkg::psr_flags  q_flags,
	output exec_pkg::psr_flags  flags,
	output logic                wb_valid,
	output exec_pkg::reg_idx    wb_rd,
	output exec_pkg::word       wb_value
);

	exec_pkg::word regs [NUM_REGS];
	logic          execute;

	assign execute = cycle == exec_pkg::EXECUTE;

	assign rd_value_a = regs[addr_a];
	assign rd_value_b = regs[addr_b];

	assign wb_valid = execute && writes_rd;
	assign wb_rd = rd;
	assign wb_value = q;

	// results land on the edge that closes EXECUTE
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
			flags <= '0;
		end else if (execute) begin
			if (writes_rd)
				regs[rd] <= q;
			if (set_flags)
				flags <= q_flags;
		end
	end

endmodule

//--- hdl/alu.sv
module alu (
	input  exec_pkg::alu_op    op,
	input  exec_pkg::word      a,
	input  exec_pkg::word      b,
	input  logic               c_in,
	input  logic               v_in,
	output exec_pkg::word      q,
	output exec_pkg::psr_flags q_flags
);

	exec_pkg::word x;
	exec_pkg::word y;
	logic          carry;
	logic          arith;
	logic [32:0]   sum;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// adder setup
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// every subtraction becomes x + ~y + carry, so C comes out as not-borrow
	always_comb begin
		x = a;
		y = b;
		carry = 1'b0;
		arith = 1'b1;

		unique case (op)
			exec_pkg::ALU_ADD, exec_pkg::ALU_CMN: carry = 1'b0;
			exec_pkg::ALU_ADC:                    carry = c_in;
			exec_pkg::ALU_SUB, exec_pkg::ALU_CMP: begin
				y = ~b;
				carry = 1'b1;
			end
			exec_pkg::ALU_SBC: begin
				y = ~b;
				carry = c_in;
			end
			exec_pkg::ALU_RSB: begin
				x = b;
				y = ~a;
				carry = 1'b1;
			end
			exec_pkg::ALU_RSC: begin
				x = b;
				y = ~a;
				carry = c_in;
			end
			default: arith = 1'b0;
		endcase
	end

	assign sum = {1'b0, x} + {1'b0, y} + {32'd0, carry};

	always_comb begin
		unique case (op)
			exec_pkg::ALU_AND, exec_pkg::ALU_TST: q = a & b;
			exec_pkg::ALU_EOR, exec_pkg::ALU_TEQ: q = a ^ b;
			exec_pkg::ALU_ORR:                    q = a | b;
			exec_pkg::ALU_MOV:                    q = b;
			exec_pkg::ALU_BIC:                    q = a & ~b;
			exec_pkg::ALU_MVN:                    q = ~b;
			default:                              q = sum[31:0];
		endcase

		q_flags.n = q[31];
		q_flags.z = q == 32'd0;

		// logical ops pass the shifter carry and leave V alone
		q_flags.c = arith ? sum[32] : c_in;
		q_flags.v = arith ? (x[31] == y[31]) && (sum[31] != x[31]) : v_in;
	end

endmodule

//--- hdl/barrel_shifter.sv
module barrel_shifter (
	input  exec_pkg::word       operand,
	input  exec_pkg::shift_kind kind,
	input  exec_pkg::shift_amt  amount,
	input  logic                c_in,
	output exec_pkg::word       result,
	output logic                c_out
);

	logic [4:0]  n;
	logic        big;
	logic [32:0] lsl_w;
	logic [32:0] lsr_w;
	logic [32:0] asr_w;
	logic [63:0] ror_w;

	assign n = amount[4:0];
	assign big = |amount[7:5];

	// the extra bit of each wide result catches the last bit shifted out
	assign lsl_w = {1'b0, operand} << n;
	assign lsr_w = {operand, 1'b0} >> n;
	assign asr_w = $signed({operand, 1'b0}) >>> n;
	assign ror_w = {operand, operand} >> n;

	always_comb begin
		result = operand;
		c_out = c_in;

		if (amount != 8'd0) begin
			unique case (kind)
				exec_pkg::SHIFT_LSL: begin
					result = big ? 32'd0 : lsl_w[31:0];
					if (big)
						c_out = (amount == 8'd32) ? operand[0] : 1'b0;
					else
						c_out = lsl_w[32];
				end

				exec_pkg::SHIFT_LSR: begin
					result = big ? 32'd0 : lsr_w[32:1];
					if (big)
						c_out = (amount == 8'd32) ? operand[31] : 1'b0;
					else
						c_out = lsr_w[0];
				end

				exec_pkg::SHIFT_ASR: begin
					result = big ? {32{operand[31]}} : asr_w[32:1];
					c_out = big ? operand[31] : asr_w[0];
				end

				// rotation only sees the amount modulo 32
				exec_pkg::SHIFT_ROR: begin
					result = ror_w[31:0];
					c_out = ror_w[31];
				end
			endcase
		end
	end

endmodule

//--- hdl/operand_select.sv
module operand_select (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 issue,
	input  exec_pkg::data_decode data,
	input  exec_pkg::snd_decode  snd,
	input  exec_pkg::ctrl_cycle  cycle,
	input  exec_pkg::ctrl_cycle  next_cycle,
	input  exec_pkg::word        rd_value_a,
	input  exec_pkg::word        rd_value_b,
	input  exec_pkg::word        q_shifter,
	input  logic                 c_shifter,
	input  exec_pkg::psr_flags   flags,
	output exec_pkg::alu_op      alu,
	output exec_pkg::word        alu_a,
	output exec_pkg::word        alu_b,
	output logic                 c_in,
	output exec_pkg::word        shift_in,
	output exec_pkg::shift_kind  shift_kind_out,
	output exec_pkg::shift_amt   shifter_shift,
	output exec_pkg::reg_idx     rd,
	output logic                 writes_rd,
	output logic                 set_flags
);

	logic          held_is_imm;
	logic          held_by_reg;
	logic          shifted;
	logic [7:0]    held_imm;
	exec_pkg::word saved_base;
	exec_pkg::word snd_raw;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// operand muxing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign snd_raw = held_is_imm ? {24'd0, held_imm} : rd_value_b;

	// rn sits on port a in every cycle except the indirect amount fetch
	assign alu_a = rd_value_a;

	// for a register amount, rm was parked in saved_base one cycle earlier
	assign shift_in = held_by_reg ? saved_base : snd_raw;

	// after WITH_SHIFT the shifted value waits in saved_base for EXECUTE
	assign alu_b = shifted ? saved_base : snd_raw;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// held instruction state
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			held_is_imm <= 1'b0;
			held_by_reg <= 1'b0;
			shifted <= 1'b0;
			writes_rd <= 1'b0;
			set_flags <= 1'b0;
		end else if (issue) begin
			held_is_imm <= snd.is_imm;
			held_by_reg <= snd.shift_by_reg && !snd.is_imm;
			shifted <= next_cycle != exec_pkg::EXECUTE;
			writes_rd <= data.writes_rd;
			set_flags <= data.set_flags;
		end
	end

	always_ff @(posedge clk) begin
		unique0 case (cycle)
			exec_pkg::ISSUE:
				if (issue) begin
					alu <= data.op;
					rd <= data.rd;

					// without a real shift the shifter carry is the old C flag
					c_in <= flags.c;

					held_imm <= snd.imm;
					shift_kind_out <= snd.kind;
					shifter_shift <= {3'b000, snd.shift_imm};
				end

			exec_pkg::RD_INDIRECT_SHIFT: begin
				saved_base <= rd_value_b;
				shifter_shift <= rd_value_a[7:0];
			end

			exec_pkg::WITH_SHIFT: begin
				saved_base <= q_shifter;
				c_in <= c_shifter;
			end
		endcase
	end

endmodule

//--- hdl/exec_sequencer.sv
module exec_sequencer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 issue,
	input  exec_pkg::data_decode data,
	input  exec_pkg::snd_decode  snd,
	output exec_pkg::ctrl_cycle  cycle,
	output exec_pkg::ctrl_cycle  next_cycle,
	output exec_pkg::reg_idx     addr_a,
	output exec_pkg::reg_idx     addr_b,
	output logic                 busy
);

	exec_pkg::reg_idx held_rn;
	exec_pkg::reg_idx held_rm;
	exec_pkg::reg_idx held_rs;

	always_comb begin
		next_cycle = cycle;

		unique case (cycle)
			exec_pkg::ISSUE:
				if (issue) begin
					if (snd.shift_by_reg && !snd.is_imm)
						next_cycle = exec_pkg::RD_INDIRECT_SHIFT;
					else if (snd.shift_imm != 5'd0)
						next_cycle = exec_pkg::WITH_SHIFT;
					else
						next_cycle = exec_pkg::EXECUTE;
				end

			exec_pkg::RD_INDIRECT_SHIFT: next_cycle = exec_pkg::WITH_SHIFT;
			exec_pkg::WITH_SHIFT:        next_cycle = exec_pkg::EXECUTE;
			exec_pkg::EXECUTE:           next_cycle = exec_pkg::ISSUE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			cycle <= exec_pkg::ISSUE;
		else
			cycle <= next_cycle;
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			held_rn <= data.rn;
			held_rm <= snd.rm;
			held_rs <= snd.rs;
		end
	end

	// port a reads rs only while the shift amount is being fetched
	assign addr_a = (cycle == exec_pkg::RD_INDIRECT_SHIFT) ? held_rs : held_rn;
	assign addr_b = held_rm;

	assign busy = cycle != exec_pkg::ISSUE;

endmodule

//--- hdl/insn_decode.sv
module insn_decode (
	input  exec_pkg::word        insn,
	output exec_pkg::data_decode data,
	output exec_pkg::snd_decode  snd
);

	exec_pkg::alu_op op;

	assign op = exec_pkg::alu_op'(insn[24:21]);

	always_comb begin
		data.op = op;
		data.set_flags = insn[20];
		data.rn = insn[19:16];
		data.rd = insn[15:12];

		// the compare group only touches the flags
		data.writes_rd = !(op inside {exec_pkg::ALU_TST, exec_pkg::ALU_TEQ,
			exec_pkg::ALU_CMP, exec_pkg::ALU_CMN});
	end

	always_comb begin
		snd.is_imm = insn[25];
		snd.imm = insn[7:0];
		snd.rm = insn[3:0];
		snd.rs = insn[11:8];

		if (insn[25]) begin
			// an 8 bit immediate rotated right by twice the rotate field
			snd.kind = exec_pkg::SHIFT_ROR;
			snd.shift_imm = {insn[11:8], 1'b0};
			snd.shift_by_reg = 1'b0;
		end else begin
			snd.kind = exec_pkg::shift_kind'(insn[6:5]);
			snd.shift_by_reg = insn[4];

			// with a register amount the immediate field holds rs instead
			if (insn[4])
				snd.shift_imm = 5'd0;
			else
				snd.shift_imm = insn[11:7];
		end
	end

endmodule

//--- hdl/exec_pkg.sv
package exec_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// basic widths
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_idx;

	// immediate shift amounts use only the low 5 bits
	typedef logic [7:0]  shift_amt;

	localparam int num_regs = 16;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// in the order of the opcode field, bits 24:21 of the instruction
	typedef enum logic [3:0] {
		ALU_AND,
		ALU_EOR,
		ALU_SUB,
		ALU_RSB,
		ALU_ADD,
		ALU_ADC,
		ALU_SBC,
		ALU_RSC,
		ALU_TST,
		ALU_TEQ,
		ALU_CMP,
		ALU_CMN,
		ALU_ORR,
		ALU_MOV,
		ALU_BIC,
		ALU_MVN
	} alu_op;

	typedef enum logic [1:0] {
		SHIFT_LSL,
		SHIFT_LSR,
		SHIFT_ASR,
		SHIFT_ROR
	} shift_kind;

	typedef enum logic [1:0] {
		ISSUE,
		RD_INDIRECT_SHIFT,
		WITH_SHIFT,
		EXECUTE
	} ctrl_cycle;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// decoded instruction
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} psr_flags;

	typedef struct packed {
		alu_op  op;
		logic   set_flags;
		reg_idx rn;
		reg_idx rd;
		logic   writes_rd;
	} data_decode;

	typedef struct packed {
		logic       is_imm;
		logic [7:0] imm;
		reg_idx     rm;
		reg_idx     rs;
		shift_kind  kind;
		logic [4:0] shift_imm;
		logic       shift_by_reg;
	} snd_decode;

endpackage
